/* Bender.yml */
package:
  name: wb_bus

sources:
  # design sources, package first
  - target: any(simulation, synthesis)
    files:
      - rtl/wb_bus_pkg.sv
      - rtl/wb_timeout_counter.sv
      - rtl/wbs_sub_arbiter.sv
      - rtl/wb_reg_slave.sv
      - rtl/wb_bus_top.sv

  # testbench and bound checks
  - target: simulation
    files:
      - sim/wb_bus_assertions.sv
      - sim/wb_bus_tb.sv

/* rtl/wb_bus_pkg.sv */
package wb_bus_pkg;

  // bus widths
  localparam int WB_AW = 32;
  localparam int WB_DW = 32;
  // one select bit per data byte
  localparam int WB_SW = WB_DW / 8;

  // byte address, also used for window bounds
  typedef logic [WB_AW-1:0] wb_addr_t;

  // master side request
  // cyc and stb travel beside it as plain wires
  typedef struct packed {
    // write enable, low for reads
    logic             we;
    // byte lanes of the write
    logic [WB_SW-1:0] sel;
    // byte address
    wb_addr_t         adr;
    // write data
    logic [WB_DW-1:0] dat;
  } wb_req_t;

  // slave side response
  // ack and err are one-cycle pulses, never together
  typedef struct packed {
    // read data, valid only with ack
    logic [WB_DW-1:0] dat;
    // transfer done
    logic             ack;
    // transfer failed
    logic             err;
  } wb_rsp_t;

endpackage

/* rtl/wb_bus_top.sv */
module wb_bus_top
  import wb_bus_pkg::*;
(
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  logic    wbm_cyc_i,
  input  logic    wbm_stb_i,
  input  wb_req_t wbm_req_i,
  output wb_rsp_t wbm_rsp_o
);

  localparam int N_SLAVES = 3;
  localparam int TIMEOUT  = 10;

  // address map, slave 0 in the low slot
  localparam wb_addr_t [N_SLAVES-1:0] SLAVE_ADDR = {
    32'h3000_0000, 32'h2000_0000, 32'h1000_0000
  };
  localparam wb_addr_t [N_SLAVES-1:0] SLAVE_HIGH = {
    32'h3000_000F, 32'h2000_00FF, 32'h1000_00FF
  };

  logic    [N_SLAVES-1:0] slv_cyc;
  logic    [N_SLAVES-1:0] slv_stb;
  // one request fans out to every slave
  wb_req_t                slv_req;
  // responses indexed by slave
  wb_rsp_t [N_SLAVES-1:0] slv_rsp;

  wbs_sub_arbiter #(
    .N_SLAVES  (N_SLAVES),
    .SLAVE_ADDR(SLAVE_ADDR),
    .SLAVE_HIGH(SLAVE_HIGH),
    .TIMEOUT   (TIMEOUT)
  ) u_arbiter (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wbm_cyc_i(wbm_cyc_i),
    .wbm_stb_i(wbm_stb_i),
    .wbm_req_i(wbm_req_i),
    .wbm_rsp_o(wbm_rsp_o),
    .wbs_cyc_o(slv_cyc),
    .wbs_stb_o(slv_stb),
    .wbs_req_o(slv_req),
    .wbs_rsp_i(slv_rsp)
  );

  // fast bank
  wb_reg_slave #(
    .N_REGS     (16),
    .WAIT_CYCLES(0)
  ) u_slave0 (
    .wb_clk_i(wb_clk_i),
    .wb_rst_i(wb_rst_i),
    .cyc_i   (slv_cyc[0]),
    .stb_i   (slv_stb[0]),
    .req_i   (slv_req),
    .rsp_o   (slv_rsp[0])
  );

  // slow bank
  wb_reg_slave #(
    .N_REGS     (8),
    .WAIT_CYCLES(3)
  ) u_slave1 (
    .wb_clk_i(wb_clk_i),
    .wb_rst_i(wb_rst_i),
    .cyc_i   (slv_cyc[1]),
    .stb_i   (slv_stb[1]),
    .req_i   (slv_req),
    .rsp_o   (slv_rsp[1])
  );

  // slower than the watchdog, always times out
  wb_reg_slave #(
    .N_REGS     (4),
    .WAIT_CYCLES(20)
  ) u_slave2 (
    .wb_clk_i(wb_clk_i),
    .wb_rst_i(wb_rst_i),
    .cyc_i   (slv_cyc[2]),
    .stb_i   (slv_stb[2]),
    .req_i   (slv_req),
    .rsp_o   (slv_rsp[2])
  );

endmodule

/* rtl/wb_reg_slave.sv */
module wb_reg_slave
  import wb_bus_pkg::*;
#(
  parameter int N_REGS      = 16,
  parameter int WAIT_CYCLES = 0
) (
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  logic    cyc_i,
  input  logic    stb_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  localparam int          IW   = (N_REGS > 1) ? $clog2(N_REGS) : 1;
  localparam int          CW   = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;
  localparam int unsigned LOAD = (WAIT_CYCLES > 0) ? WAIT_CYCLES - 1 : 0;

  logic [WB_DW-1:0] regs_q [N_REGS];
  logic             busy_q;
  logic [CW-1:0]    wait_q;
  wb_req_t          req_q;
  logic             strobe;
  logic             fire;
  wb_req_t          cur_req;
  logic [WB_AW-3:0] word;
  logic [IW-1:0]    idx;
  logic             in_range;
  logic             ack_q;
  logic             err_q;
  logic [WB_DW-1:0] rdat_q;

  // new strobes are dropped while a delayed access is pending
  assign strobe = cyc_i && stb_i && !busy_q;
  // zero wait answers on the sampling edge itself
  assign fire    = (WAIT_CYCLES == 0) ? strobe : (busy_q && (wait_q == '0));
  assign cur_req = (WAIT_CYCLES == 0) ? req_i : req_q;
  // word index from bit 2 up
  assign word     = cur_req.adr[WB_AW-1:2];
  assign idx      = word[IW-1:0];
  assign in_range = (word < N_REGS);

  // hold the request through the wait states
  always_ff @(posedge wb_clk_i) begin
    if (strobe) begin
      req_q <= req_i;
    end
  end

  // wait-state counter
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      busy_q <= 1'b0;
      wait_q <= '0;
    end else if (strobe && (WAIT_CYCLES != 0)) begin
      busy_q <= 1'b1;
      wait_q <= CW'(LOAD);
    end else if (busy_q) begin
      if (wait_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        wait_q <= wait_q - 1'b1;
      end
    end
  end

  // register file and response pulse
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      for (int r = 0; r < N_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      if (fire) begin
        if (in_range) begin
          ack_q <= 1'b1;
          // byte lanes with sel set only
          if (cur_req.we) begin
            for (int b = 0; b < WB_SW; b++) begin
              if (cur_req.sel[b]) begin
                regs_q[idx][8*b +: 8] <= cur_req.dat[8*b +: 8];
              end
            end
          end
        end else begin
          // past the last register
          err_q <= 1'b1;
        end
      end
    end
  end

  // read word, old contents on a write
  always_ff @(posedge wb_clk_i) begin
    if (fire && in_range) begin
      rdat_q <= regs_q[idx];
    end
  end

  assign rsp_o = '{dat: rdat_q, ack: ack_q, err: err_q};

endmodule

/* rtl/wb_timeout_counter.sv */
module wb_timeout_counter #(
  parameter int TIMEOUT = 10
) (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic clear_i,
  output logic timeout_o
);

  // wide enough to hold TIMEOUT itself
  localparam int CW = $clog2(TIMEOUT + 1);

  logic [CW-1:0] cnt_q;

  // count up while not cleared, hold at the limit
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || clear_i) begin
      cnt_q <= '0;
    end else if (!timeout_o) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // stays high until cleared
  assign timeout_o = (cnt_q == CW'(TIMEOUT));

endmodule

/* rtl/wbs_sub_arbiter.sv */
module wbs_sub_arbiter
  import wb_bus_pkg::*;
#(
  parameter int                      N_SLAVES   = 3,
  parameter wb_addr_t [N_SLAVES-1:0] SLAVE_ADDR = '0,
  parameter wb_addr_t [N_SLAVES-1:0] SLAVE_HIGH = '0,
  parameter int                      TIMEOUT    = 10
) (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic                   wbm_cyc_i,
  input  logic                   wbm_stb_i,
  input  wb_req_t                wbm_req_i,
  output wb_rsp_t                wbm_rsp_o,
  output logic    [N_SLAVES-1:0] wbs_cyc_o,
  output logic    [N_SLAVES-1:0] wbs_stb_o,
  output wb_req_t                wbs_req_o,
  input  wb_rsp_t [N_SLAVES-1:0] wbs_rsp_i
);

  localparam int IDXW = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

  typedef enum logic {
    ST_IDLE,
    ST_WAIT
  } state_t;

  // one-hot to index, highest set bit wins
  function automatic logic [IDXW-1:0] encode(input logic [N_SLAVES-1:0] onehot);
    logic [IDXW-1:0] idx;
    idx = '0;
    for (int i = 0; i < N_SLAVES; i++) begin
      if (onehot[i]) begin
        idx = IDXW'(i);
      end
    end
    return idx;
  endfunction

  // stage 0, master inputs
  logic                mst_cyc_q;
  logic                mst_stb_q;
  wb_req_t             mst_req_q;
  // stage 1, window compare plus aligned request
  logic [N_SLAVES-1:0] hit_q;
  logic                cyc1_q;
  logic                stb1_q;
  wb_req_t             req1_q;
  // stage 2, encoded hit and base of that window
  logic                hit_any2_q;
  logic [IDXW-1:0]     idx2_q;
  wb_addr_t            base2_q;
  logic                cyc2_q;
  logic                stb2_q;
  wb_req_t             req2_q;
  // control stage
  state_t              state_q;
  logic [N_SLAVES-1:0] act_q;
  logic [N_SLAVES-1:0] strobe_q;
  logic                fsm_err_q;
  wb_req_t             slv_req_q;
  logic                tmo;
  // response path
  logic [N_SLAVES-1:0]            slv_ack_q;
  logic [N_SLAVES-1:0]            slv_err_q;
  logic [N_SLAVES-1:0][WB_DW-1:0] slv_dat_q;
  logic [IDXW-1:0]                act_idx;
  logic                           slv_done;
  logic                           sel_ack_q;
  logic                           sel_err_q;
  logic [WB_DW-1:0]               sel_dat_q;
  // master output registers
  logic                           mst_ack_q;
  logic                           mst_err_q;
  logic [WB_DW-1:0]               mst_dat_q;

  // register the master, edge k
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      mst_cyc_q <= 1'b0;
      mst_stb_q <= 1'b0;
    end else begin
      mst_cyc_q <= wbm_cyc_i;
      mst_stb_q <= wbm_stb_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    mst_req_q <= wbm_req_i;
  end

  // decode, edge k+1
  // inclusive bounds on both ends
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      hit_q  <= '0;
      cyc1_q <= 1'b0;
      stb1_q <= 1'b0;
    end else begin
      cyc1_q <= mst_cyc_q;
      stb1_q <= mst_stb_q;
      for (int i = 0; i < N_SLAVES; i++) begin
        hit_q[i] <= (mst_req_q.adr >= SLAVE_ADDR[i]) && (mst_req_q.adr <= SLAVE_HIGH[i]);
      end
    end
  end

  // encode and fetch the window base, edge k+2
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      hit_any2_q <= 1'b0;
      cyc2_q     <= 1'b0;
      stb2_q     <= 1'b0;
    end else begin
      hit_any2_q <= |hit_q;
      cyc2_q     <= cyc1_q;
      stb2_q     <= stb1_q;
    end
  end

  // request payload follows the decode two deep
  always_ff @(posedge wb_clk_i) begin
    req1_q  <= mst_req_q;
    req2_q  <= req1_q;
    idx2_q  <= encode(hit_q);
    base2_q <= SLAVE_ADDR[encode(hit_q)];
  end

  // bus watchdog, runs only while waiting on a slave
  wb_timeout_counter #(
    .TIMEOUT(TIMEOUT)
  ) u_timeout (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .clear_i  (state_q != ST_WAIT),
    .timeout_o(tmo)
  );

  // a response from the slave we are waiting on
  assign slv_done = |((slv_ack_q | slv_err_q) & act_q);

  // control, edge k+3
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q   <= ST_IDLE;
      act_q     <= '0;
      strobe_q  <= '0;
      fsm_err_q <= 1'b0;
    end else begin
      // strobes and err are single pulses
      strobe_q  <= '0;
      fsm_err_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (cyc2_q && stb2_q) begin
            if (!hit_any2_q) begin
              // no window claims it
              fsm_err_q <= 1'b1;
              act_q     <= '0;
            end else begin
              act_q    <= N_SLAVES'(1) << idx2_q;
              strobe_q <= N_SLAVES'(1) << idx2_q;
              state_q  <= ST_WAIT;
            end
          end
        end
        ST_WAIT: begin
          if (slv_done) begin
            state_q <= ST_IDLE;
            act_q   <= '0;
          end else if (tmo) begin
            // dead slave, drop it so a late ack is masked
            fsm_err_q <= 1'b1;
            act_q     <= '0;
            state_q   <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // rebase the address into the slave's window
  always_ff @(posedge wb_clk_i) begin
    if (state_q == ST_IDLE) begin
      slv_req_q.we  <= req2_q.we;
      slv_req_q.sel <= req2_q.sel;
      slv_req_q.adr <= req2_q.adr - base2_q;
      slv_req_q.dat <= req2_q.dat;
    end
  end

  // slave side outputs, edge k+4
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wbs_cyc_o <= '0;
      wbs_stb_o <= '0;
    end else begin
      wbs_cyc_o <= strobe_q;
      wbs_stb_o <= strobe_q;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    wbs_req_o <= slv_req_q;
  end

  // capture every slave response
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      slv_ack_q <= '0;
      slv_err_q <= '0;
    end else begin
      for (int i = 0; i < N_SLAVES; i++) begin
        slv_ack_q[i] <= wbs_rsp_i[i].ack;
        slv_err_q[i] <= wbs_rsp_i[i].err;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    for (int i = 0; i < N_SLAVES; i++) begin
      slv_dat_q[i] <= wbs_rsp_i[i].dat;
    end
  end

  // pick the active slave, others are ignored
  assign act_idx = encode(act_q);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      sel_ack_q <= 1'b0;
      sel_err_q <= 1'b0;
    end else begin
      sel_ack_q <= |(slv_ack_q & act_q);
      sel_err_q <= |(slv_err_q & act_q);
    end
  end

  always_ff @(posedge wb_clk_i) begin
    sel_dat_q <= slv_dat_q[act_idx];
    mst_dat_q <= sel_dat_q;
  end

  // master outputs
  // slave err and arbiter err share one line
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      mst_ack_q <= 1'b0;
      mst_err_q <= 1'b0;
    end else begin
      mst_ack_q <= sel_ack_q;
      mst_err_q <= sel_err_q | fsm_err_q;
    end
  end

  assign wbm_rsp_o = '{dat: mst_dat_q, ack: mst_ack_q, err: mst_err_q};

endmodule

/* sim/wb_bus_assertions.sv */
module wb_bus_assertions
  import wb_bus_pkg::*;
#(
  parameter int N_SLAVES = 3
) (
  input logic                wb_clk_i,
  input logic                wb_rst_i,
  input logic [N_SLAVES-1:0] wbs_cyc_i,
  input logic [N_SLAVES-1:0] wbs_stb_i,
  input logic                waiting_i,
  input wb_rsp_t             wbm_rsp_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // read back by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // at most one slave selected
  a_cyc_onehot: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $onehot0(wbs_cyc_i))
  else begin
    fail_cnt++;
    $error("slave cyc vector has more than one bit set");
  end

  // ack and err exclusive
  a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wbm_rsp_i.ack && wbm_rsp_i.err))
  else begin
    fail_cnt++;
    $error("master ack and err high in the same cycle");
  end

  // single-cycle ack
  a_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wbm_rsp_i.ack |=> !wbm_rsp_i.ack)
  else begin
    fail_cnt++;
    $error("master ack held longer than one cycle");
  end

  // single-cycle err
  a_err_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wbm_rsp_i.err |=> !wbm_rsp_i.err)
  else begin
    fail_cnt++;
    $error("master err held longer than one cycle");
  end

  // slave strobe on the bus only from a decision taken in idle
  // decision edge is two edges before the strobe is sampled
  a_no_strobe_wait: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wbs_stb_i != '0) |-> !$past(waiting_i, 2))
  else begin
    fail_cnt++;
    $error("slave strobe raised while waiting on a slave");
  end

endmodule

/* sim/wb_bus_tb.sv */
module wb_bus_tb
  import wb_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // watchdog of the top level
  localparam int TIMEOUT    = 10;
  // tests take about 1300 cycles incl reset
  localparam int MAX_CYCLES = 2000;
  // slave 0 words 0..15, slave 1 from word 16
  localparam int N_MODEL    = 24;
  // gaps, below the map and just past each high bound
  localparam wb_addr_t HOLES [7] = '{
    32'h0000_0000, 32'h0fff_fffc, 32'h1000_0100, 32'h1800_0000,
    32'h2000_0100, 32'h3000_0010, 32'hffff_fffc
  };

  // outcome of one transfer
  typedef struct packed {
    logic             is_err;
    logic [WB_DW-1:0] dat;
    logic [7:0]       min_lat;
    logic [7:0]       max_lat;
  } expect_t;

  logic    wb_clk_i;
  logic    wb_rst_i;
  logic    wbm_cyc_i;
  logic    wbm_stb_i;
  wb_req_t wbm_req_i;
  wb_rsp_t wbm_rsp_o;

  logic [WB_DW-1:0] model [N_MODEL];
  int               seed = 32'h1d2c;
  int               cyc_cnt = 0;
  int               checks = 0;
  int               errors = 0;
  int               tests_run = 0;
  int               checks_mark = 0;
  int               errors_mark = 0;
  // transfer in flight, set by stimulus and cleared by the compare
  logic             pend = 1'b0;
  expect_t          exp_q;
  logic             exp_we;
  int               issue_k;

  wb_bus_top u_wb_bus_top (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wbm_cyc_i(wbm_cyc_i),
    .wbm_stb_i(wbm_stb_i),
    .wbm_req_i(wbm_req_i),
    .wbm_rsp_o(wbm_rsp_o)
  );

  bind wbs_sub_arbiter wb_bus_assertions #(
    .N_SLAVES(N_SLAVES)
  ) u_bus_assertions (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wbs_cyc_i(wbs_cyc_o),
    .wbs_stb_i(wbs_stb_o),
    .waiting_i(state_q == ST_WAIT),
    .wbm_rsp_i(wbm_rsp_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  // edges so far, edge k is cyc_cnt+1 when driving
  always @(posedge wb_clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  function automatic logic [WB_DW-1:0] merge_bytes(input logic [WB_DW-1:0] old,
                                                   input logic [WB_DW-1:0] dat,
                                                   input logic [WB_SW-1:0] sel);
    logic [WB_DW-1:0] res;
    res = old;
    for (int b = 0; b < WB_SW; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = dat[8*b +: 8];
      end
    end
    return res;
  endfunction

  // expected outcome from the address map, updates the model on writes
  function automatic void predict(input logic we, input wb_addr_t adr,
                                  input logic [WB_SW-1:0] sel, input logic [WB_DW-1:0] dat,
                                  output expect_t e);
    wb_addr_t base;
    int       nregs;
    int       first;
    int       wait_st;
    int       word;
    e = '0;
    if (adr >= 32'h1000_0000 && adr <= 32'h1000_00ff) begin
      base    = 32'h1000_0000;
      nregs   = 16;
      first   = 0;
      wait_st = 0;
    end else if (adr >= 32'h2000_0000 && adr <= 32'h2000_00ff) begin
      base    = 32'h2000_0000;
      nregs   = 8;
      first   = 16;
      wait_st = 3;
    end else if (adr >= 32'h3000_0000 && adr <= 32'h3000_000f) begin
      // dead device, watchdog answers
      e.is_err  = 1'b1;
      e.min_lat = 8'(TIMEOUT + 4);
      e.max_lat = 8'(TIMEOUT + 8);
      return;
    end else begin
      // no window, arbiter err
      e.is_err  = 1'b1;
      e.min_lat = 8'd4;
      e.max_lat = 8'd4;
      return;
    end
    word      = int'((adr - base) >> 2);
    e.min_lat = 8'(8 + wait_st);
    e.max_lat = e.min_lat;
    if (word >= nregs) begin
      e.is_err = 1'b1;
    end else begin
      e.dat = model[first + word];
      if (we) begin
        model[first + word] = merge_bytes(model[first + word], dat, sel);
      end
    end
  endfunction

  task automatic compare_value(input string name, input logic [WB_DW-1:0] got,
                               input logic [WB_DW-1:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("ERR %0t %s got %0h exp %0h", $time, name, got, want);
    end
  endtask

  // one-cycle strobe, then wait for the compare to retire it
  task automatic run_access(input logic we, input wb_addr_t adr,
                            input logic [WB_SW-1:0] sel, input logic [WB_DW-1:0] dat);
    expect_t e;
    @(posedge wb_clk_i);
    #1;
    predict(we, adr, sel, dat, e);
    exp_q     = e;
    exp_we    = we;
    issue_k   = cyc_cnt + 1;
    pend      = 1'b1;
    wbm_cyc_i = 1'b1;
    wbm_stb_i = 1'b1;
    wbm_req_i = '{we: we, sel: sel, adr: adr, dat: dat};
    @(posedge wb_clk_i);
    #1;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    wait (!pend);
  endtask

  task automatic write_random(input wb_addr_t adr);
    logic [WB_DW-1:0] dat;
    logic [WB_SW-1:0] sel;
    dat = $random(seed);
    sel = $random(seed);
    run_access(1'b1, adr, sel, dat);
  endtask

  task automatic read_back(input wb_addr_t adr);
    run_access(1'b0, adr, 4'hf, '0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge wb_clk_i);
  endtask

  task automatic log_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d checks, %0d errors", tests_run, name,
             checks - checks_mark, errors - errors_mark);
    checks_mark = checks;
    errors_mark = errors;
  endtask

  // outputs sampled at the falling edge
  always @(negedge wb_clk_i) begin
    int lat;
    if (!wb_rst_i && !pend) begin
      // nothing outstanding, bus stays quiet
      assert (!wbm_rsp_o.ack && !wbm_rsp_o.err) else begin
        errors++;
        $display("ERR %0t wbm_rsp_o ack/err got %b/%b exp 0/0 while idle", $time,
                 wbm_rsp_o.ack, wbm_rsp_o.err);
      end
    end else if (!wb_rst_i) begin
      lat = cyc_cnt - issue_k;
      if (wbm_rsp_o.ack || wbm_rsp_o.err) begin
        compare_value("wbm_rsp_o.ack", wbm_rsp_o.ack, !exp_q.is_err);
        compare_value("wbm_rsp_o.err", wbm_rsp_o.err, exp_q.is_err);
        checks++;
        assert (lat >= int'(exp_q.min_lat) && lat <= int'(exp_q.max_lat)) else begin
          errors++;
          $display("ERR %0t wbm_rsp_o latency got %0d exp %0d..%0d", $time, lat,
                   exp_q.min_lat, exp_q.max_lat);
        end
        // read data only meaningful on a read ack
        if (!exp_we && !exp_q.is_err) begin
          compare_value("wbm_rsp_o.dat", wbm_rsp_o.dat, exp_q.dat);
        end
        pend = 1'b0;
      end else if (lat > int'(exp_q.max_lat)) begin
        errors++;
        $display("no response on the master port %0d cycles after the request, at %0t",
                 lat, $time);
        pend = 1'b0;
      end
    end
  end

  initial begin
    wait (cyc_cnt >= MAX_CYCLES);
    $display("run stopped after %0d cycles before the tests finished", cyc_cnt);
    $display("Verification failed");
    $finish;
  end

  initial begin
    int unsigned afails;
    wb_rst_i  = 1'b1;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    wbm_req_i = '0;
    for (int i = 0; i < N_MODEL; i++) begin
      model[i] = '0;
    end
    repeat (16) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;

    // first transfer straight out of reset, then quiet bus
    write_random(32'h1000_0000);
    read_back(32'h1000_0000);
    idle_cycles(10);
    log_test("after reset");

    // two merged writes per word, then read back
    for (int i = 0; i < 16; i++) begin
      write_random(32'h1000_0000 + 4 * i);
      write_random(32'h1000_0000 + 4 * i);
    end
    for (int i = 0; i < 16; i++) begin
      read_back(32'h1000_0000 + 4 * i);
    end
    log_test("slave 0 data");

    for (int i = 0; i < 8; i++) begin
      write_random(32'h2000_0000 + 4 * i);
      write_random(32'h2000_0000 + 4 * i);
    end
    for (int i = 0; i < 8; i++) begin
      read_back(32'h2000_0000 + 4 * i);
    end
    log_test("slave 1 data");

    // reads and writes alternate
    for (int i = 0; i < 7; i++) begin
      run_access(i[0], HOLES[i], 4'hf, 32'h0bad_0000 + i);
    end
    log_test("unmapped");

    // idle gap lets the late slave ack drain unseen
    write_random(32'h3000_0004);
    idle_cycles(15);
    read_back(32'h3000_0008);
    idle_cycles(15);
    write_random(32'h1000_0014);
    read_back(32'h1000_0014);
    log_test("dead slave");

    // index past N_REGS, then every stored word
    write_random(32'h1000_0040);
    write_random(32'h1000_00fc);
    write_random(32'h2000_0020);
    read_back(32'h2000_00f0);
    for (int i = 0; i < 16; i++) begin
      read_back(32'h1000_0000 + 4 * i);
    end
    for (int i = 0; i < 8; i++) begin
      read_back(32'h2000_0000 + 4 * i);
    end
    log_test("range error");

    afails = u_wb_bus_top.u_arbiter.u_bus_assertions.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, checks, errors, afails);
    if (errors == 0 && afails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* wb_bus.f */
rtl/wb_bus_pkg.sv
rtl/wb_timeout_counter.sv
rtl/wbs_sub_arbiter.sv
rtl/wb_reg_slave.sv
rtl/wb_bus_top.sv
sim/wb_bus_assertions.sv
sim/wb_bus_tb.sv
